//--- Makefile
# Verilator build and run for the board glue testbench

SIM       ?= verilator
TOP       ?= tb_board_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
SIM_FLAGS ?= --binary --timing -Wno-fatal
FAIL_MSG  ?= >>> FAIL

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
HEADERS := $(wildcard verification/*.svh)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '$(FAIL_MSG)' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- project.f
+incdir+verification
verilog/board_pkg.sv
verilog/rst_ctrl.sv
verilog/switch_sync.sv
verilog/uart_tx.sv
verilog/rs485_ctrl.sv
verilog/board_top.sv
verification/tb_board_top.sv

//--- verification/tb_tests.svh
// ########################################
// Directed tests for the board glue, included
// into the testbench module. Each prints one line.
// ########################################

`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

  // Led stays dark for the whole hold and lights on the last edge
  task automatic check_reset_release();
    logic expected;
    for (int i = 1; i <= HoldCycles; i++) begin
      tick();
      expected = (i == HoldCycles);
      if (led_bootok !== expected) report_mismatch("led_bootok_o", led_bootok, expected);
    end
  endtask

  task automatic reset_release_timing();
    if (led_bootok !== 1'b0) report_mismatch("led_bootok_o", led_bootok, 1'b0);
    reset = 1'b0;  // Clock already locked
    check_reset_release();
    repeat (3) tick();
    pll_locked = 1'b0;  // Lock lost for one cycle
    tick();
    if (led_bootok !== 1'b0) report_mismatch("led_bootok_o", led_bootok, 1'b0);
    pll_locked = 1'b1;
    check_reset_release();
    finish_test("reset release timing");
  endtask

  task automatic switch_word_packing();
    logic [31:0]                     r;
    logic [board_pkg::GpInWidth-1:0] expected;
    logic [board_pkg::GpInWidth-1:0] previous;
    repeat (4) begin
      r        = next_random();
      nav_sw   = r[4:0];
      usr_sw   = r[12:5];
      sel_sw   = r[15:13];
      // Closed switch reads one
      expected[board_pkg::UsrSwWidth-1:0]                       = ~usr_sw;
      expected[board_pkg::UsrSwWidth +: board_pkg::NavSwWidth]  = ~nav_sw;
      expected[board_pkg::GpInWidth-1 -: board_pkg::SelSwWidth] = ~sel_sw;
      previous = gp_in;
      tick();
      if (gp_in !== previous) report_mismatch("gp_in_o", gp_in, previous);  // Still in sync
      tick();
      if (gp_in !== expected) report_mismatch("gp_in_o", gp_in, expected);
    end
    finish_test("switch word packing");
  endtask

  task automatic frame_content();
    logic [31:0] r;
    int unsigned edges;
    repeat (3) begin
      r       = next_random();
      tx_data = r[7:0];
      tx_req  = 1'b1;
      wait_start_bit(edges);
      if (edges != 0) check_frame_bits(r[7:0]);
      release_request();
      wait_driver_off(edges);
    end
    finish_test("frame content");
  endtask

  task automatic driver_turnaround();
    logic [31:0] r;
    int unsigned edges;
    r       = next_random();
    tx_data = r[7:0];
    tx_req  = 1'b1;
    edges   = 0;
    while (de !== 1'b1 && edges < 50) begin
      tick();
      edges++;
      if (di !== 1'b1) report_mismatch("rs485_di_o", di, 1'b1);  // Idle before the driver
    end
    if (ren !== de) report_mismatch("rs485_ren_o", ren, de);
    wait_start_bit(edges);
    if (edges != SwitchCycles + 1)
      report_mismatch("cycles from de_o to start bit", edges, SwitchCycles + 1);
    check_frame_bits(r[7:0]);
    release_request();
    wait_driver_off(edges);
    if (edges + 1 != SwitchCycles)  // Counted from the end of the stop bit
      report_mismatch("cycles from stop bit end to de_o low", edges + 1, SwitchCycles);
    finish_test("driver turnaround");
  endtask

  task automatic receive_gating();
    logic [31:0] r;
    int unsigned edges;
    rx_check_en = 1'b1;
    gated_ticks = 0;
    repeat (20) tick();  // Idle line where rx follows ro
    r       = next_random();
    tx_data = r[7:0];
    tx_req  = 1'b1;
    wait_start_bit(edges);
    if (edges != 0) check_frame_bits(r[7:0]);
    release_request();
    wait_driver_off(edges);
    repeat (10) tick();
    if (gated_ticks == 0) report_failure("driver never came on, receive gating not exercised");
    rx_check_en = 1'b0;
    ro          = 1'b1;
    finish_test("receive gating");
  endtask

  task automatic back_to_back_frames();
    logic [31:0] r;
    int unsigned edges;
    logic        dropped;
    r       = next_random();
    tx_data = r[7:0];
    tx_req  = 1'b1;
    wait_start_bit(edges);
    if (edges != 0) check_frame_bits(r[7:0]);
    release_request();
    tx_data = r[15:8];  // Second request lands inside the driver hold
    tx_req  = 1'b1;
    dropped = 1'b0;
    edges   = 0;
    while (di !== 1'b0 && edges < 50) begin
      tick();
      edges++;
      if (de !== 1'b1) dropped = 1'b1;
    end
    if (dropped) report_failure("driver switched off between back to back frames");
    if (di !== 1'b0) report_failure("second start bit never appeared on rs485_di_o");
    else check_frame_bits(r[15:8]);
    release_request();
    wait_driver_off(edges);
    finish_test("back to back frames");
  endtask

`endif

//--- verification/tb_board_top.sv
// ########################################
// Testbench for the board glue top level. Drives
// reset, switches and the transmit port, checks the
// RS-485 pins. Directed tests come from tb_tests.svh.
// ########################################

`default_nettype none

module tb_board_top;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned ClkPeriodNs  = 20;
  localparam int unsigned ResetCycles  = 16;
  localparam int unsigned HoldCycles   = 8;   // Reset hold after release
  localparam int unsigned ClksPerBit   = 10;  // 50 MHz clock at 5 MBd
  localparam int unsigned SwitchCycles = 6;   // 100 ns over 20 ns plus one
  localparam int unsigned FrameBits    = 10;  // Start, eight data, stop
  localparam int unsigned NumFrames    = 7;
  localparam int unsigned NumTests     = 6;
  localparam int unsigned WatchdogCycles = NumFrames * FrameBits * ClksPerBit + 400 * NumTests;
  localparam logic [31:0] Seed         = 32'hefd9b892;

  logic                                clk_sys;
  logic                                reset;
  logic                                pll_locked;
  logic [board_pkg::NavSwWidth-1:0]    nav_sw;
  logic [board_pkg::UsrSwWidth-1:0]    usr_sw;
  logic [board_pkg::SelSwWidth-1:0]    sel_sw;
  logic                                tx_req;
  logic [board_pkg::UartDataWidth-1:0] tx_data;
  logic                                ro;
  logic                                led_bootok;
  logic [board_pkg::GpInWidth-1:0]     gp_in;
  logic                                tx_ack;
  logic                                di;
  logic                                de;
  logic                                ren;
  logic                                rx;

  logic [31:0] rand_state;
  logic        rx_check_en;  // Receive gating checked on every tick
  int unsigned gated_ticks;  // Ticks seen with the driver on
  int unsigned test_errors;
  int unsigned total_errors;
  int unsigned tests_run;
  int unsigned tests_failed;

  board_top #(
    .SysClkFreq        (50_000_000),
    .BaudRate          (5_000_000),
    .Rs485SwitchDelayNs(100),
    .ResetHoldCycles   (HoldCycles)
  ) i_dut (
    .clk_sys_i   (clk_sys),
    .reset_i     (reset),
    .pll_locked_i(pll_locked),
    .nav_sw_i    (nav_sw),
    .usr_sw_i    (usr_sw),
    .sel_sw_i    (sel_sw),
    .tx_req_i    (tx_req),
    .tx_data_i   (tx_data),
    .rs485_ro_i  (ro),
    .led_bootok_o(led_bootok),
    .gp_in_o     (gp_in),
    .tx_ack_o    (tx_ack),
    .rs485_di_o  (di),
    .rs485_de_o  (de),
    .rs485_ren_o (ren),
    .rs485_rx_o  (rx)
  );

  always #(ClkPeriodNs / 2) clk_sys = ~clk_sys;

  initial begin : watchdog
    #(WatchdogCycles * ClkPeriodNs);
    $display("Watchdog expired after %0d cycles, the tests did not finish", WatchdogCycles);
    $display(">>> FAIL");
    $finish;
  end

  function automatic logic [31:0] next_random();
    rand_state = rand_state ^ (rand_state << 13);
    rand_state = rand_state ^ (rand_state >> 17);
    rand_state = rand_state ^ (rand_state << 5);
    return rand_state;
  endfunction

  task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] expected);
    $display("** Error at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, expected);
    test_errors++;
  endtask

  task automatic report_failure(string what);
    $display("At %0t ns: %s", $time, what);
    test_errors++;
  endtask

  // One falling edge where inputs change and outputs are read
  task automatic tick();
    logic [31:0] r;
    @(negedge clk_sys);
    if (rx_check_en) begin
      if (de) gated_ticks++;
      if (ren !== de) report_mismatch("rs485_ren_o", ren, de);
      if (rx !== (de ? 1'b1 : ro)) report_mismatch("rs485_rx_o", rx, de ? 1'b1 : ro);
      r = next_random();
      ro = r[16];  // New line level for the next cycle
    end
  endtask

  // Ticks until di shows the start bit or zero when it never comes
  task automatic wait_start_bit(output int unsigned edges);
    edges = 0;
    while (di !== 1'b0 && edges < 200) begin
      tick();
      edges++;
    end
    if (di !== 1'b0) begin
      report_failure("start bit never appeared on rs485_di_o");
      edges = 0;
    end
  endtask

  // Starts on the tick that shows the start bit and returns once ack is high
  task automatic check_frame_bits(logic [7:0] data);
    logic [9:0]  frame;
    int unsigned edges;
    frame = {1'b1, data, 1'b0};  // Bit 0 goes out first
    edges = 0;
    for (int i = 0; i < FrameBits; i++) begin
      repeat ((i == 0) ? ClksPerBit / 2 : ClksPerBit) tick();  // Bit centre
      edges += (i == 0) ? ClksPerBit / 2 : ClksPerBit;
      if (di !== frame[i]) report_mismatch("rs485_di_o", di, frame[i]);
      if (tx_ack !== 1'b0) report_mismatch("tx_ack_o", tx_ack, 1'b0);
    end
    while (tx_ack !== 1'b1 && edges < 200) begin
      tick();
      edges++;
    end
    if (edges != FrameBits * ClksPerBit)
      report_mismatch("cycles from start bit to tx_ack_o", edges, FrameBits * ClksPerBit);
  endtask

  // Fourth phase where ack must follow one edge later
  task automatic release_request();
    tx_req = 1'b0;
    tick();
    if (tx_ack !== 1'b0) report_mismatch("tx_ack_o", tx_ack, 1'b0);
  endtask

  task automatic wait_driver_off(output int unsigned edges);
    edges = 0;
    while (de !== 1'b0 && edges < 100) begin
      tick();
      edges++;
    end
    if (de !== 1'b0) report_failure("rs485_de_o never dropped after the frame");
  endtask

  task automatic finish_test(string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("%s passed", name);
    end else begin
      $display("%s failed with %0d errors", name, test_errors);
      tests_failed++;
    end
    total_errors += test_errors;
    test_errors = 0;
  endtask

  `include "tb_tests.svh"

  initial begin
    clk_sys      = 1'b0;
    reset        = 1'b1;  // Button pressed at power up
    pll_locked   = 1'b1;
    nav_sw       = '1;    // All switches open
    usr_sw       = '1;
    sel_sw       = '1;
    tx_req       = 1'b0;
    tx_data      = '0;
    ro           = 1'b1;
    rand_state   = Seed;
    rx_check_en  = 1'b0;
    gated_ticks  = 0;
    test_errors  = 0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (ResetCycles) @(negedge clk_sys);
    reset_release_timing();
    switch_word_packing();
    frame_content();
    driver_turnaround();
    receive_gating();
    back_to_back_frames();
    $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors);
    if (tests_failed == 0 && total_errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule : tb_board_top

`default_nettype wire

//--- verilog/board_pkg.sv
// ########################################
// Shared widths and timing constants for the
// board glue logic. Referenced by scoped name.
// ########################################

`default_nettype none

package board_pkg;

  // Switch groups on the board, all pulled up and active low at the pins
  parameter int unsigned NavSwWidth = 5;  // Joystick directions plus press
  parameter int unsigned UsrSwWidth = 8;  // User DIP switches
  parameter int unsigned SelSwWidth = 3;  // Software selection switches

  // General purpose input word seen by software
  // Selection in the high bits, joystick in the middle, user switches low
  parameter int unsigned GpInWidth = SelSwWidth + NavSwWidth + UsrSwWidth;

  // Serial frame payload
  parameter int unsigned UartDataWidth = 8;  // One start, eight data, one stop

  // Used to turn a clock frequency into a whole period in ns
  parameter int unsigned NsPerSecond = 1_000_000_000;

endpackage : board_pkg

`default_nettype wire

//--- verilog/board_top.sv
// ########################################
// Board glue top level. Turns clock, baud and
// transceiver delay into cycle counts and wires
// reset, switches and the RS-485 transmit path.
// ########################################

`default_nettype none

module board_top #(
  parameter int unsigned SysClkFreq         = 50_000_000,
  parameter int unsigned BaudRate           = 921_600,
  parameter int unsigned Rs485SwitchDelayNs = 90 + 10,  // Transceiver 90 ns plus margin
  parameter int unsigned ResetHoldCycles    = 255
) (
  input  logic                                clk_sys_i,
  input  logic                                reset_i,       // Push button
  input  logic                                pll_locked_i,
  input  logic [board_pkg::NavSwWidth-1:0]    nav_sw_i,
  input  logic [board_pkg::UsrSwWidth-1:0]    usr_sw_i,
  input  logic [board_pkg::SelSwWidth-1:0]    sel_sw_i,
  input  logic                                tx_req_i,
  input  logic [board_pkg::UartDataWidth-1:0] tx_data_i,
  input  logic                                rs485_ro_i,
  output logic                                led_bootok_o,  // Lit once out of reset
  output logic [board_pkg::GpInWidth-1:0]     gp_in_o,
  output logic                                tx_ack_o,
  output logic                                rs485_di_o,
  output logic                                rs485_de_o,
  output logic                                rs485_ren_o,
  output logic                                rs485_rx_o
);

  localparam int unsigned ClksPerBit  = SysClkFreq / BaudRate;
  localparam int unsigned ClkPeriodNs = board_pkg::NsPerSecond / SysClkFreq;
  // Always one extra cycle, the delay rarely divides evenly into periods
  localparam int unsigned SwitchCycles = (Rs485SwitchDelayNs / ClkPeriodNs) + 1;
  // Driver hold after a frame, same as the turnaround works well
  localparam int unsigned TransmitEndCycles = SwitchCycles;

  logic sys_rst;
  logic tx_enable;
  logic tx_bit;
  logic line_ready;

  assign led_bootok_o = ~sys_rst;

  rst_ctrl #(
    .ResetHoldCycles(ResetHoldCycles)
  ) u_rst_ctrl (
    .clk_sys_i   (clk_sys_i),
    .reset_i     (reset_i),
    .pll_locked_i(pll_locked_i),
    .rst_sys_o   (sys_rst)
  );

  switch_sync u_switch_sync (
    .clk_sys_i(clk_sys_i),
    .rst_i    (sys_rst),
    .nav_sw_i (nav_sw_i),
    .usr_sw_i (usr_sw_i),
    .sel_sw_i (sel_sw_i),
    .gp_in_o  (gp_in_o)
  );

  uart_tx #(
    .ClksPerBit(ClksPerBit)
  ) u_uart_tx (
    .clk_sys_i   (clk_sys_i),
    .rst_i       (sys_rst),
    .tx_req_i    (tx_req_i),
    .tx_data_i   (tx_data_i),
    .tx_ack_o    (tx_ack_o),
    .line_ready_i(line_ready),
    .tx_enable_o (tx_enable),
    .tx_bit_o    (tx_bit)
  );

  // Transmit data reaches the pins only through the direction control
  rs485_ctrl #(
    .SwitchCycles     (SwitchCycles),
    .TransmitEndCycles(TransmitEndCycles)
  ) u_rs485_ctrl (
    .clk_sys_i   (clk_sys_i),
    .rst_i       (sys_rst),
    .tx_enable_i (tx_enable),
    .tx_bit_i    (tx_bit),
    .line_ready_o(line_ready),
    .ro_i        (rs485_ro_i),
    .rx_o        (rs485_rx_o),
    .di_o        (rs485_di_o),
    .de_o        (rs485_de_o),
    .ren_o       (rs485_ren_o)
  );

endmodule : board_top

`default_nettype wire

//--- verilog/rs485_ctrl.sv
// ########################################
// RS-485 transceiver direction control. Waits
// out the switch time before data, holds the
// driver after data and masks receive meanwhile.
// ########################################

`default_nettype none

module rs485_ctrl #(
  parameter int unsigned SwitchCycles      = 6,
  parameter int unsigned TransmitEndCycles = 6
) (
  input  logic clk_sys_i,
  input  logic rst_i,
  input  logic tx_enable_i,   // Transmitter owns the line
  input  logic tx_bit_i,      // Serial level from the transmitter
  output logic line_ready_o,  // Transceiver has turned around
  input  logic ro_i,          // Receiver output pin
  output logic rx_o,          // Receive data to the board
  output logic di_o,          // Driver input pin
  output logic de_o,          // Driver enable, active high
  output logic ren_o          // Receiver enable, active low
);

  // Turn-on is counted from de_o rising
  localparam int unsigned SwitchLoad = (SwitchCycles > 0) ? SwitchCycles - 1 : 0;
  // Hold is counted from the edge where the transmitter drops its enable,
  // which is seen here one edge later
  localparam int unsigned HoldLoad   = (TransmitEndCycles > 1) ? TransmitEndCycles - 2 : 0;
  localparam int unsigned MaxLoad    = (SwitchLoad > HoldLoad) ? SwitchLoad : HoldLoad;
  localparam int unsigned CntWidth   = (MaxLoad > 0) ? $clog2(MaxLoad + 1) : 1;

  typedef enum logic [1:0] {
    s_off,        // Receiving, driver off
    s_switching,  // Driver on, waiting for the turnaround
    s_on,         // Data may flow
    s_holding     // Frame done, driver kept on a little longer
  } state_e;

  state_e              state_q;
  logic [CntWidth-1:0] delay_cnt_q;  // Shared by turn-on and hold
  logic                driver_on;
  logic                data_pass;

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      state_q     <= s_off;
      delay_cnt_q <= '0;
    end else begin
      case (state_q)
        s_off: begin
          if (tx_enable_i) begin
            state_q     <= s_switching;
            delay_cnt_q <= CntWidth'(SwitchLoad);
          end
        end

        s_switching: begin
          if (delay_cnt_q != '0) begin
            delay_cnt_q <= delay_cnt_q - 1'b1;
          end else begin
            state_q <= s_on;
          end
        end

        s_on: begin
          if (!tx_enable_i) begin
            state_q     <= s_holding;
            delay_cnt_q <= CntWidth'(HoldLoad);
          end
        end

        s_holding: begin
          if (tx_enable_i) begin
            state_q <= s_on;  // Back to back frame, no second turnaround
          end else if (delay_cnt_q != '0) begin
            delay_cnt_q <= delay_cnt_q - 1'b1;
          end else begin
            state_q <= s_off;
          end
        end

        default: state_q <= s_off;
      endcase
    end
  end

  assign driver_on = (state_q != s_off);
  assign data_pass = (state_q == s_on) || (state_q == s_holding);

  assign de_o         = driver_on;
  assign ren_o        = driver_on;  // High disables the receiver
  assign line_ready_o = (state_q == s_on);
  assign di_o         = data_pass ? tx_bit_i : 1'b1;  // Idle until switched
  assign rx_o         = ren_o ? 1'b1 : ro_i;          // Own echo is masked

endmodule : rs485_ctrl

`default_nettype wire

//--- verilog/rst_ctrl.sv
// ########################################
// Board reset generator. Keeps the system reset
// asserted until the button is released, the
// clock is locked and a hold count has run out.
// ########################################

`default_nettype none

module rst_ctrl #(
  parameter int unsigned ResetHoldCycles = 16
) (
  input  logic clk_sys_i,
  input  logic reset_i,       // Push button, active high
  input  logic pll_locked_i,  // Clock generator lock
  output logic rst_sys_o      // Board wide reset, active high
);

  localparam int unsigned CntWidth = $clog2(ResetHoldCycles + 1);

  logic                rst_cond;
  logic [CntWidth-1:0] hold_cnt_q;  // Cycles left before release
  logic                rst_sys_q;

  // Any reason to hold the board in reset
  assign rst_cond = reset_i | ~pll_locked_i;

  always_ff @(posedge clk_sys_i) begin
    if (rst_cond) begin
      hold_cnt_q <= CntWidth'(ResetHoldCycles);  // Reload while pressed or unlocked
      rst_sys_q  <= 1'b1;
    end else begin
      if (hold_cnt_q != '0) begin
        hold_cnt_q <= hold_cnt_q - 1'b1;
      end
      // Let go on the edge that takes the count down to zero
      rst_sys_q <= (hold_cnt_q > CntWidth'(1));
    end
  end

  // Registered, so the rest of the board sees one clean edge
  assign rst_sys_o = rst_sys_q;

endmodule : rst_ctrl

`default_nettype wire

//--- verilog/switch_sync.sv
// ########################################
// Brings the active-low board switches into the
// system clock domain and packs them into the
// general purpose input word, one for "on".
// ########################################

`default_nettype none

module switch_sync (
  input  logic                             clk_sys_i,
  input  logic                             rst_i,
  input  logic [board_pkg::NavSwWidth-1:0] nav_sw_i,  // Joystick, active low
  input  logic [board_pkg::UsrSwWidth-1:0] usr_sw_i,  // User switches, active low
  input  logic [board_pkg::SelSwWidth-1:0] sel_sw_i,  // Selection switches, active low
  output logic [board_pkg::GpInWidth-1:0]  gp_in_o
);

  // First stage, still raw pin polarity and possibly metastable
  logic [board_pkg::GpInWidth-1:0] sw_meta_q;
  // Second stage, stable and inverted
  logic [board_pkg::GpInWidth-1:0] sw_sync_q;

  // Word order fixed here: selection high, joystick middle, user low
  always_ff @(posedge clk_sys_i) begin
    sw_meta_q <= {sel_sw_i, nav_sw_i, usr_sw_i};
  end

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      sw_sync_q <= '0;  // All switches read off during reset
    end else begin
      // Pull-ups make an open switch read high, flip it for software
      sw_sync_q <= ~sw_meta_q;
    end
  end

  assign gp_in_o = sw_sync_q;

endmodule : switch_sync

`default_nettype wire

//--- verilog/uart_tx.sv
// ########################################
// Byte transmitter behind a four-phase req/ack
// port. Requests the line driver before each
// frame and sends 8N1, LSB first.
// ########################################

`default_nettype none

module uart_tx #(
  parameter int unsigned ClksPerBit = 16
) (
  input  logic                                clk_sys_i,
  input  logic                                rst_i,
  input  logic                                tx_req_i,      // Held high until ack
  input  logic [board_pkg::UartDataWidth-1:0] tx_data_i,     // Stable while req high
  output logic                                tx_ack_o,      // Frame fully sent
  input  logic                                line_ready_i,  // Driver switched on
  output logic                                tx_enable_o,   // We want the line
  output logic                                tx_bit_o       // Serial level, idle high
);

  localparam int unsigned FrameBits = board_pkg::UartDataWidth + 2;  // Start and stop added
  localparam int unsigned BaudWidth = $clog2(ClksPerBit + 1);
  localparam int unsigned BitWidth  = $clog2(FrameBits);

  typedef enum logic [1:0] {
    s_idle,       // Waiting for a request
    s_wait_line,  // Driver asked for, transceiver still turning
    s_shift,      // Frame on the wire
    s_ack         // Done, waiting for req to drop
  } state_e;

  state_e               state_q;
  logic [BaudWidth-1:0] baud_cnt_q;  // Cycles left in the current bit
  logic [BitWidth-1:0]  bit_cnt_q;   // Index of the bit on the line, 0 is start
  // Stop, data, start and one idle bit at the bottom
  logic [FrameBits:0]   shift_q;

  always_ff @(posedge clk_sys_i) begin
    if (rst_i) begin
      state_q    <= s_idle;
      baud_cnt_q <= '0;
      bit_cnt_q  <= '0;
      shift_q    <= '1;  // Line idles high
    end else begin
      case (state_q)
        s_idle: begin
          if (tx_req_i) begin
            shift_q <= {1'b1, tx_data_i, 2'b01};  // Bit 0 keeps the line idle for now
            state_q <= s_wait_line;
          end
        end

        s_wait_line: begin
          // Start bit goes out on the edge that sees the driver ready
          if (line_ready_i) begin
            shift_q    <= {1'b1, shift_q[FrameBits:1]};
            baud_cnt_q <= BaudWidth'(ClksPerBit - 1);
            bit_cnt_q  <= '0;
            state_q    <= s_shift;
          end
        end

        s_shift: begin
          if (baud_cnt_q != '0) begin
            baud_cnt_q <= baud_cnt_q - 1'b1;
          end else if (bit_cnt_q == BitWidth'(FrameBits - 1)) begin
            state_q <= s_ack;  // Stop bit has had its full time
          end else begin
            shift_q    <= {1'b1, shift_q[FrameBits:1]};  // Next bit, ones fill behind
            baud_cnt_q <= BaudWidth'(ClksPerBit - 1);
            bit_cnt_q  <= bit_cnt_q + 1'b1;
          end
        end

        s_ack: begin
          // Fourth phase, ack falls one edge after req
          if (!tx_req_i) begin
            state_q <= s_idle;
          end
        end

        default: state_q <= s_idle;
      endcase
    end
  end

  assign tx_enable_o = (state_q == s_wait_line) || (state_q == s_shift);
  assign tx_ack_o    = (state_q == s_ack);  // Rises as enable falls
  assign tx_bit_o    = shift_q[0];

endmodule : uart_tx

`default_nettype wire
